// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
		repeat (16) @(posedge clk_o);
		// release away from the rising edge
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

	always #5 clk_o = ~clk_o;

endmodule

// File: dv/vector_core_checker.sv
`timescale 1ns/100ps

module vector_core_checker
(
	input logic                      clk,
	input logic                      rst_n_i,
	input logic                      instr_valid_i,
	input vec_isa_pkg::vec_instr_t   instr_i,
	input logic                      wb_cyc_i,
	input logic                      wb_stb_i,
	input logic                      wb_ack_i,
	input logic                      ex1_valid_i,
	input vec_pipe_pkg::vec_bypass_t byp_ex2_i,
	input vec_pipe_pkg::vec_bypass_t byp_wb_i
);

	// an ack needs cyc and stb on the edge before
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
		else $error("wishbone ack without cyc and stb");

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("wishbone ack held for two cycles");

	// pipeline must stay empty while reset is low
	valids_in_reset: assert property (@(posedge clk)
		!rst_n_i |-> !ex1_valid_i && !byp_ex2_i.write && !byp_wb_i.write)
		else $error("stage valid high during reset");

	instr_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		instr_valid_i |-> !$isunknown(instr_i))
		else $error("unknown bits on a valid instruction");

endmodule

bind vector_core vector_core_checker u_checker
(
	.clk           (clk),
	.rst_n_i       (rst_n_i),
	.instr_valid_i (instr_valid_i),
	.instr_i       (instr_i),
	.wb_cyc_i      (wb_cyc_i),
	.wb_stb_i      (wb_stb_i),
	.wb_ack_i      (wb_ack_o),
	.ex1_valid_i   (ex1_valid),
	.byp_ex2_i     (byp_ex2),
	.byp_wb_i      (byp_wb)
);

// File: dv/vector_core_tb.sv
`timescale 1ns/100ps

module vector_core_tb;

	import vec_isa_pkg::*;
	import vec_pipe_pkg::*;

	// issue slots per test from the seeding up to the random program with its gaps
	localparam int ISSUE_SLOTS    = 8 + 30 + 24 * 3 + 4 + 24 + 300 * 4;
	localparam int NUM_READS      = 32 + 4 * NUM_VREGS * LANES + 2 * LANES;
	localparam int TIMEOUT_CYCLES = 16 + ISSUE_SLOTS + 5 * 4 + 3 * NUM_READS + 200;

	logic                clk;
	logic                rst_n;
	logic                instr_valid_i;
	vec_instr_t          instr_i;
	logic                wb_cyc_i;
	logic                wb_stb_i;
	logic                wb_we_i;
	logic [WB_ADR_W-1:0] wb_adr_i;
	lane_t               wb_dat_o;
	logic                wb_ack_o;

	lane_t       model [NUM_VREGS][LANES];
	logic [31:0] lfsr;
	vreg_idx_t   last_dst;
	int          cycles;
	int          checks;
	int          errors;
	int          test_errors;

	tb_clock_gen u_clk_gen
	(
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	vector_core uut
	(
		.clk           (clk),
		.rst_n_i       (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o)
	);

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic lane_t ref_lane(input vec_op_e op, input lane_t a, input lane_t b);
		case (op)
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			default: return a + b;
		endcase
	endfunction

	// updates the reference model in issue order, then drives one cycle
	task automatic issue(input vec_op_e op, input vreg_idx_t dst, input lane_mask_t mask,
		input vreg_idx_t src_a, input vreg_idx_t src_b, input logic [9:0] imm);
		vec_instr_t in;
		lane_t      b;
		lane_t      res [LANES];
		in      = '0;
		in.op   = op;
		in.dst  = dst;
		in.mask = mask;
		if (op == OP_ADDI)
		begin
			in.payload.ri.src_a = src_a;
			in.payload.ri.imm   = imm;
		end
		else
		begin
			in.payload.rr.src_a = src_a;
			in.payload.rr.src_b = src_b;
		end
		for (int l = 0; l < LANES; l++)
		begin
			b      = (op == OP_ADDI) ? {{22{imm[9]}}, imm} : model[src_b][l];
			res[l] = ref_lane(op, model[src_a][l], b);
		end
		for (int l = 0; l < LANES; l++)
		begin
			if (mask[l])
				model[dst][l] = res[l];
		end
		last_dst      = dst;
		instr_valid_i = 1'b1;
		instr_i       = in;
		@(negedge clk);
		instr_valid_i = 1'b0;
	endtask

	task automatic issue_random(input vec_op_e op, input vreg_idx_t src_a);
		vreg_idx_t  dst;
		lane_mask_t mask;
		vreg_idx_t  src_b;
		logic [9:0] imm;
		dst   = vreg_idx_t'(rand_bits(5));
		mask  = lane_mask_t'(rand_bits(16));
		src_b = vreg_idx_t'(rand_bits(5));
		imm   = 10'(rand_bits(10));
		issue(op, dst, mask, src_a, src_b, imm);
	endtask

	task automatic idle(input int n);
		instr_valid_i = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic read_lane(input vreg_idx_t r, input logic [3:0] l, output lane_t v,
		output logic ok);
		int waited;
		ok       = 1'b0;
		v        = '0;
		waited   = 0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b0;
		wb_adr_i = {r, l};
		while (!ok && waited < 4)
		begin
			@(negedge clk);
			waited++;
			if (wb_ack_o)
			begin
				ok = 1'b1;
				v  = wb_dat_o;
			end
		end
		// stb stays up over one more edge while the ack is still pending
		@(negedge clk);
		if (ok && wb_ack_o)
		begin
			$display("wishbone ack held for two cycles on register %0d lane %0d", r, l);
			test_errors++;
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		if (!ok)
		begin
			$display("no wishbone ack for register %0d lane %0d", r, l);
			test_errors++;
		end
	endtask

	task automatic compare_lane(input string name, input lane_t exp, input lane_t act);
		checks++;
		if (exp !== act)
		begin
			$display("FAIL %s expected %h got %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic verify_lane(input vreg_idx_t r, input logic [3:0] l);
		lane_t v;
		logic  ok;
		read_lane(r, l, v, ok);
		if (ok)
			compare_lane($sformatf("wb_dat_o reg %0d lane %0d", r, l), model[r][l], v);
	endtask

	task automatic verify_reg(input vreg_idx_t r);
		for (int l = 0; l < LANES; l++)
			verify_lane(r, 4'(l));
	endtask

	task automatic verify_all();
		for (int r = 0; r < NUM_VREGS; r++)
			verify_reg(vreg_idx_t'(r));
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d errors", name, test_errors);
		errors      = errors + test_errors;
		test_errors = 0;
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("timeout, run still going after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	initial
	begin
		vec_op_e    op;
		vreg_idx_t  src;
		vreg_idx_t  dst;
		lane_mask_t mask;
		logic [8:0] imm_mag;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		wb_cyc_i      = 1'b0;
		wb_stb_i      = 1'b0;
		wb_we_i       = 1'b0;
		wb_adr_i      = '0;
		lfsr          = 32'h9cde;
		last_dst      = '0;
		cycles        = 0;
		checks        = 0;
		errors        = 0;
		test_errors   = 0;
		for (int r = 0; r < NUM_VREGS; r++)
		begin
			for (int l = 0; l < LANES; l++)
				model[r][l] = '0;
		end
		@(posedge rst_n);
		@(negedge clk);

		for (int i = 0; i < 32; i++)
		begin
			src = vreg_idx_t'(rand_bits(5));
			verify_lane(src, 4'(rand_bits(4)));
		end
		finish_test("1 reset reads zero");

		// seed some registers, then a chain through ex1
		for (int i = 1; i <= 8; i++)
			issue(OP_ADDI, vreg_idx_t'(i), 16'hffff, 5'd0, 5'd0, 10'(rand_bits(10)));
		for (int i = 0; i < 30; i++)
			issue_random(vec_op_e'(4'(i % 5)), last_dst);
		idle(4);
		verify_all();
		finish_test("2 back-to-back dependencies");

		for (int i = 0; i < 24; i++)
		begin
			issue_random(vec_op_e'(4'(rand_bits(3) % 5)), last_dst);
			idle(1 + int'(rand_bits(1)));
		end
		idle(4);
		verify_all();
		finish_test("3 distance two and three");

		// lanes 14 and 15 fall through to the register file
		issue(OP_ADDI, 5'd20, 16'h00ff, 5'd3, 5'd0, 10'h155);
		issue(OP_ADDI, 5'd20, 16'h0ff0, 5'd4, 5'd0, 10'h2aa);
		issue(OP_ADDI, 5'd20, 16'h3c3c, 5'd5, 5'd0, 10'h0f0);
		issue(OP_OR, 5'd21, 16'hffff, 5'd20, 5'd20, 10'd0);
		idle(4);
		verify_reg(5'd20);
		verify_reg(5'd21);
		finish_test("4 overlapping masks");

		for (int i = 0; i < 24; i++)
		begin
			dst     = vreg_idx_t'(rand_bits(5));
			mask    = lane_mask_t'(rand_bits(16));
			src     = vreg_idx_t'(rand_bits(5));
			imm_mag = 9'(rand_bits(9));
			issue(OP_ADDI, dst, mask, src, 5'd0, {i[0], imm_mag});
		end
		idle(4);
		verify_all();
		finish_test("5 immediates");

		for (int i = 0; i < 300; i++)
		begin
			op  = vec_op_e'(4'(rand_bits(3) % 6));
			src = vreg_idx_t'(rand_bits(5));
			issue_random(op, src);
			idle(int'(rand_bits(2)));
		end
		idle(4);
		verify_all();
		finish_test("6 random program");

		$display("%0d lane checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: project.f
rtl/vec_isa_pkg.sv
rtl/vec_pipe_pkg.sv
rtl/vector_register_file.sv
rtl/vector_bypass_unit.sv
rtl/vector_operand_stage.sv
rtl/vector_execute.sv
rtl/vector_core.sv
dv/tb_clock_gen.sv
dv/vector_core_checker.sv
dv/vector_core_tb.sv

// File: rtl/vec_isa_pkg.sv
package vec_isa_pkg;

	// width of the immediate field in the register-immediate form
	localparam int IMM_W = 10;

	typedef enum logic [3:0]
	{
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_ADDI = 4'h5
	} vec_op_e;

	// register-register form of the payload
	typedef struct packed
	{
		logic [4:0] src_a;
		logic [4:0] src_b;
		logic [4:0] rsvd;
	} vec_rr_t;

	// in the register-immediate form imm is sign extended and broadcast to every lane
	typedef struct packed
	{
		logic [4:0]       src_a;
		logic [IMM_W-1:0] imm;
	} vec_ri_t;

	// the same 15 bits decoded by opcode
	typedef union packed
	{
		vec_rr_t rr;
		vec_ri_t ri;
	} vec_payload_u;

	typedef struct packed
	{
		vec_op_e      op;
		logic [4:0]   dst;
		logic [15:0]  mask;
		vec_payload_u payload;
	} vec_instr_t;

endpackage

// File: rtl/vec_pipe_pkg.sv
package vec_pipe_pkg;

	localparam int LANES     = 16;
	localparam int LANE_W    = 32;
	localparam int NUM_VREGS = 32;

	// wishbone address bits 8:4 pick the register and 3:0 the lane
	localparam int WB_ADR_W  = 9;

	typedef logic [$clog2(NUM_VREGS)-1:0] vreg_idx_t;
	typedef logic [LANES-1:0]             lane_mask_t;
	typedef logic [LANE_W-1:0]            lane_t;

	// lane 0 sits in the low 32 bits
	typedef lane_t [LANES-1:0] vector_t;

	// one in-flight result that also serves as the register file write port
	typedef struct packed
	{
		logic       write;
		vreg_idx_t  vreg;
		lane_mask_t mask;
		vector_t    value;
	} vec_bypass_t;

endpackage

// File: rtl/vector_bypass_unit.sv
`timescale 1ns/100ps

module vector_bypass_unit
(
	input  vec_pipe_pkg::vreg_idx_t   reg_sel_i,
	input  vec_pipe_pkg::vector_t     data_i,
	output vec_pipe_pkg::vector_t     value_o,
	input  vec_pipe_pkg::vec_bypass_t byp1_i,
	input  vec_pipe_pkg::vec_bypass_t byp2_i,
	input  vec_pipe_pkg::vec_bypass_t byp3_i
);

	import vec_pipe_pkg::*;

	logic hit1;
	logic hit2;
	logic hit3;

	assign hit1 = byp1_i.write && (byp1_i.vreg == reg_sel_i);
	assign hit2 = byp2_i.write && (byp2_i.vreg == reg_sel_i);
	assign hit3 = byp3_i.write && (byp3_i.vreg == reg_sel_i);

	// predication means each lane can come from a different stage
	always_comb
	begin
		for (int l = 0; l < LANES; l++)
		begin
			if (hit1 && byp1_i.mask[l])
				value_o[l] = byp1_i.value[l];
			else if (hit2 && byp2_i.mask[l])
				value_o[l] = byp2_i.value[l];
			else if (hit3 && byp3_i.mask[l])
				value_o[l] = byp3_i.value[l];
			else
				value_o[l] = data_i[l];
		end
	end

endmodule

// File: rtl/vector_core.sv
`timescale 1ns/100ps

module vector_core
(
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              instr_valid_i,
	input  vec_isa_pkg::vec_instr_t           instr_i,
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	input  logic                              wb_we_i,
	input  logic [vec_pipe_pkg::WB_ADR_W-1:0] wb_adr_i,
	output vec_pipe_pkg::lane_t               wb_dat_o,
	output logic                              wb_ack_o
);

	import vec_isa_pkg::*;
	import vec_pipe_pkg::*;

	vreg_idx_t   rd_a_idx;
	vreg_idx_t   rd_b_idx;
	vector_t     rd_a;
	vector_t     rd_b;
	logic        ex1_valid;
	vec_instr_t  ex1_instr;
	vector_t     ex1_a;
	vector_t     ex1_b;
	vec_bypass_t byp_ex1;
	vec_bypass_t byp_ex2;
	vec_bypass_t byp_wb;

	vector_operand_stage u_operand
	(
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.rd_a_idx_o    (rd_a_idx),
		.rd_b_idx_o    (rd_b_idx),
		.rd_a_i        (rd_a),
		.rd_b_i        (rd_b),
		.byp_ex1_i     (byp_ex1),
		.byp_ex2_i     (byp_ex2),
		.byp_wb_i      (byp_wb),
		.ex1_valid_o   (ex1_valid),
		.ex1_instr_o   (ex1_instr),
		.ex1_a_o       (ex1_a),
		.ex1_b_o       (ex1_b)
	);

	vector_execute u_execute
	(
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ex1_valid_i (ex1_valid),
		.ex1_instr_i (ex1_instr),
		.ex1_a_i     (ex1_a),
		.ex1_b_i     (ex1_b),
		.byp_ex1_o   (byp_ex1),
		.byp_ex2_o   (byp_ex2),
		.byp_wb_o    (byp_wb)
	);

	vector_register_file u_regfile
	(
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rd_a_idx_i (rd_a_idx),
		.rd_b_idx_i (rd_b_idx),
		.rd_a_o     (rd_a),
		.rd_b_o     (rd_b),
		.wr_i       (byp_wb),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o)
	);

endmodule

// File: rtl/vector_execute.sv
`timescale 1ns/100ps

module vector_execute
(
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      ex1_valid_i,
	input  vec_isa_pkg::vec_instr_t   ex1_instr_i,
	input  vec_pipe_pkg::vector_t     ex1_a_i,
	input  vec_pipe_pkg::vector_t     ex1_b_i,
	output vec_pipe_pkg::vec_bypass_t byp_ex1_o,
	output vec_pipe_pkg::vec_bypass_t byp_ex2_o,
	output vec_pipe_pkg::vec_bypass_t byp_wb_o
);

	import vec_isa_pkg::*;
	import vec_pipe_pkg::*;

	vector_t     result;
	vec_bypass_t ex2_q;
	vec_bypass_t wb_q;

	// the immediate form was already folded into operand b
	always_comb
	begin
		for (int l = 0; l < LANES; l++)
		begin
			case (ex1_instr_i.op)
				OP_ADD,
				OP_ADDI: result[l] = ex1_a_i[l] + ex1_b_i[l];
				OP_SUB:  result[l] = ex1_a_i[l] - ex1_b_i[l];
				OP_AND:  result[l] = ex1_a_i[l] & ex1_b_i[l];
				OP_OR:   result[l] = ex1_a_i[l] | ex1_b_i[l];
				OP_XOR:  result[l] = ex1_a_i[l] ^ ex1_b_i[l];
				default: result[l] = '0;
			endcase
		end
	end

	// youngest record comes straight out of the alu
	always_comb
	begin
		byp_ex1_o.write = ex1_valid_i;
		byp_ex1_o.vreg  = ex1_instr_i.dst;
		byp_ex1_o.mask  = ex1_instr_i.mask;
		byp_ex1_o.value = result;
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ex2_q <= '0;
			wb_q  <= '0;
		end
		else
		begin
			ex2_q <= byp_ex1_o;
			wb_q  <= ex2_q;
		end
	end

	assign byp_ex2_o = ex2_q;
	// wb record also drives the register file write port
	assign byp_wb_o  = wb_q;

endmodule

// File: rtl/vector_operand_stage.sv
`timescale 1ns/100ps

module vector_operand_stage
(
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      instr_valid_i,
	input  vec_isa_pkg::vec_instr_t   instr_i,
	output vec_pipe_pkg::vreg_idx_t   rd_a_idx_o,
	output vec_pipe_pkg::vreg_idx_t   rd_b_idx_o,
	input  vec_pipe_pkg::vector_t     rd_a_i,
	input  vec_pipe_pkg::vector_t     rd_b_i,
	input  vec_pipe_pkg::vec_bypass_t byp_ex1_i,
	input  vec_pipe_pkg::vec_bypass_t byp_ex2_i,
	input  vec_pipe_pkg::vec_bypass_t byp_wb_i,
	output logic                      ex1_valid_o,
	output vec_isa_pkg::vec_instr_t   ex1_instr_o,
	output vec_pipe_pkg::vector_t     ex1_a_o,
	output vec_pipe_pkg::vector_t     ex1_b_o
);

	import vec_isa_pkg::*;
	import vec_pipe_pkg::*;

	logic    is_imm;
	lane_t   imm_lane;
	vector_t fwd_a;
	vector_t fwd_b;
	vector_t opnd_b;

	// payload layout depends on the opcode
	assign is_imm     = (instr_i.op == OP_ADDI);
	// src_a sits in the same bits of both payload forms
	assign rd_a_idx_o = instr_i.payload.rr.src_a;
	assign rd_b_idx_o = instr_i.payload.rr.src_b;

	assign imm_lane = {{(LANE_W-IMM_W){instr_i.payload.ri.imm[IMM_W-1]}},
		instr_i.payload.ri.imm};

	vector_bypass_unit u_byp_a
	(
		.reg_sel_i (rd_a_idx_o),
		.data_i    (rd_a_i),
		.value_o   (fwd_a),
		.byp1_i    (byp_ex1_i),
		.byp2_i    (byp_ex2_i),
		.byp3_i    (byp_wb_i)
	);

	vector_bypass_unit u_byp_b
	(
		.reg_sel_i (rd_b_idx_o),
		.data_i    (rd_b_i),
		.value_o   (fwd_b),
		.byp1_i    (byp_ex1_i),
		.byp2_i    (byp_ex2_i),
		.byp3_i    (byp_wb_i)
	);

	// immediate goes to every lane of operand b
	assign opnd_b = is_imm ? {LANES{imm_lane}} : fwd_b;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			ex1_valid_o <= 1'b0;
		else
			ex1_valid_o <= instr_valid_i;
	end

	always_ff @(posedge clk)
	begin
		ex1_instr_o <= instr_i;
		ex1_a_o     <= fwd_a;
		ex1_b_o     <= opnd_b;
	end

endmodule

// File: rtl/vector_register_file.sv
`timescale 1ns/100ps

module vector_register_file
(
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  vec_pipe_pkg::vreg_idx_t           rd_a_idx_i,
	input  vec_pipe_pkg::vreg_idx_t           rd_b_idx_i,
	output vec_pipe_pkg::vector_t             rd_a_o,
	output vec_pipe_pkg::vector_t             rd_b_o,
	input  vec_pipe_pkg::vec_bypass_t         wr_i,
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	input  logic                              wb_we_i,
	input  logic [vec_pipe_pkg::WB_ADR_W-1:0] wb_adr_i,
	output vec_pipe_pkg::lane_t               wb_dat_o,
	output logic                              wb_ack_o
);

	import vec_pipe_pkg::*;

	vector_t   vregs [NUM_VREGS];
	logic      wb_req;
	vreg_idx_t wb_reg;
	logic [3:0] wb_lane;

	// operand reads are combinational
	assign rd_a_o = vregs[rd_a_idx_i];
	assign rd_b_o = vregs[rd_b_idx_i];

	// writeback only touches the lanes under the mask
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			vregs <= '{default: '0};
		else if (wr_i.write)
		begin
			for (int l = 0; l < LANES; l++)
			begin
				if (wr_i.mask[l])
					vregs[wr_i.vreg][l] <= wr_i.value[l];
			end
		end
	end

	// new access when cyc and stb are up and no ack is pending
	assign wb_req  = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign wb_reg  = vreg_idx_t'(wb_adr_i[WB_ADR_W-1:4]);
	assign wb_lane = wb_adr_i[3:0];

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= wb_req;
	end

	// writes get an ack but leave the read data alone
	always_ff @(posedge clk)
	begin
		if (wb_req && !wb_we_i)
			wb_dat_o <= vregs[wb_reg][wb_lane];
	end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, then judge the log
verilator --binary --timing --assert --top-module vector_core_tb \
	-f project.f -o vector_core_sim \
	|| { echo "verilator build did not complete"; exit 1; }
./obj_dir/vector_core_sim > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log && exit 0 || exit 1
